//--- src.f
+incdir+include
design/mdu_uop_pkg.sv
design/mdu_iq_pkg.sv
design/mdu_iq_entry.sv
design/mdu_iq_queue.sv
design/mdu_issue_select.sv
design/mdu_issue_unit.sv
sim/mdu_issue_chk.sv
sim/mdu_issue_tb.sv

//--- sim/mdu_issue_tb.sv
`default_nettype none

`include "mdu_iq_settings.svh"

module mdu_issue_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mdu_uop_pkg::*;

    localparam int DEPTH       = `MDU_IQ_DEPTH;
    localparam int TEST_CYCLES = 6 + 4 + 11 + 18 + 35 + 10;  // cycles per test in run order
    localparam int CYCLE_LIMIT = 4 + 2 * TEST_CYCLES;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        flush;
    logic                        enq_valid_0;
    logic                        enq_valid_1;
    mdu_uop_t                    lane0;
    mdu_uop_t                    lane1;
    logic [`MDU_WAKE_PORTS-1:0]  wake_valid;
    preg_t [`MDU_WAKE_PORTS-1:0] wake_preg;
    logic                        mul_busy;
    logic                        div_busy;
    logic                        mul_issue_valid;
    mdu_op_e                     mul_issue_op;
    logic [`MDU_ROB_W-1:0]       mul_issue_rob;
    preg_t                       mul_issue_prs1;
    preg_t                       mul_issue_prs2;
    preg_t                       mul_issue_prd;
    logic                        div_issue_valid;
    mdu_op_e                     div_issue_op;
    logic [`MDU_ROB_W-1:0]       div_issue_rob;
    preg_t                       div_issue_prs1;
    preg_t                       div_issue_prs2;
    preg_t                       div_issue_prd;
    logic [1:0]                  credit_cnt;

    mdu_uop_t              model [$];       // oldest first
    logic [`MDU_ROB_W-1:0] issue_log [$];   // rob tags as the DUT issued them
    int                    credits;
    int                    credit_total = 0;
    int                    prev_iss;
    int                    checks = 0;
    int                    errors = 0;
    int                    cycles = 0;
    logic [31:0]           lfsr = 32'h056ce525;

    mdu_issue_unit i_dut (
        .enq_op_0       (lane0.op),
        .enq_rob_0      (lane0.rob_tag),
        .enq_prs1_0     (lane0.prs1),
        .enq_prs2_0     (lane0.prs2),
        .enq_prd_0      (lane0.prd),
        .enq_prs1_rdy_0 (lane0.prs1_rdy),
        .enq_prs2_rdy_0 (lane0.prs2_rdy),
        .enq_op_1       (lane1.op),
        .enq_rob_1      (lane1.rob_tag),
        .enq_prs1_1     (lane1.prs1),
        .enq_prs2_1     (lane1.prs2),
        .enq_prd_1      (lane1.prd),
        .enq_prs1_rdy_1 (lane1.prs1_rdy),
        .enq_prs2_rdy_1 (lane1.prs2_rdy),
        .*
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic mdu_uop_t mk(input mdu_op_e opc, input logic [`MDU_ROB_W-1:0] rob,
                                    input preg_t s1, input preg_t s2, input logic r1,
                                    input logic r2);
        return '{op: opc, rob_tag: rob, prs1: s1, prs2: s2, prd: preg_t'(rand_bits(6)),
                 prs1_rdy: r1, prs2_rdy: r2};
    endfunction

    function automatic logic is_div(input mdu_op_e opc);
        return (opc == OP_DIV) || (opc == OP_REM);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_port(input string p, input logic gv, input int ei, input mdu_op_e opc,
                              input logic [`MDU_ROB_W-1:0] rob, input preg_t s1,
                              input preg_t s2, input preg_t d);
        mdu_uop_t e;
        check_val({p, "_issue_valid"}, gv, ei >= 0);
        if (gv && ei >= 0) begin
            e = model[ei];
            check_val({p, "_issue_op"}, opc, e.op);
            check_val({p, "_issue_rob"}, rob, e.rob_tag);
            check_val({p, "_issue_prs1"}, s1, e.prs1);
            check_val({p, "_issue_prs2"}, s2, e.prs2);
            check_val({p, "_issue_prd"}, d, e.prd);
        end
    endtask

    // one cycle of dispatch and wake stimulus
    task automatic drive(input logic [1:0] ev, input mdu_uop_t u0, input mdu_uop_t u1,
                         input logic [1:0] wv, input preg_t w0, input preg_t w1);
        @(posedge clk);
        assert (int'(ev[0]) + int'(ev[1]) <= credits) else begin
            errors++;
            $display("enqueue attempted without a free credit at %0t", $time);
        end
        enq_valid_0  <= ev[0];
        enq_valid_1  <= ev[1];
        lane0        <= u0;
        lane1        <= u1;
        wake_valid   <= wv;
        wake_preg[0] <= w0;
        wake_preg[1] <= w1;
    endtask

    task automatic idle(input int n);
        repeat (n) drive(2'b00, '0, '0, 2'b00, '0, '0);
    endtask

    // scoreboard model checked mid cycle when inputs and outputs are settled
    always @(negedge clk) begin : monitor
        int mi;
        int di;
        if (rst) begin
            model.delete();
            credits  = DEPTH;
            prev_iss = 0;
        end else begin
            mi = -1;
            di = -1;
            for (int i = 0; i < model.size(); i++) begin
                if (!flush && model[i].prs1_rdy && model[i].prs2_rdy) begin
                    if (!is_div(model[i].op) && mi < 0 && !mul_busy)
                        mi = i;
                    if (is_div(model[i].op) && di < 0 && !div_busy)
                        di = i;
                end
            end
            check_port("mul", mul_issue_valid, mi, mul_issue_op, mul_issue_rob,
                       mul_issue_prs1, mul_issue_prs2, mul_issue_prd);
            check_port("div", div_issue_valid, di, div_issue_op, div_issue_rob,
                       div_issue_prs1, div_issue_prs2, div_issue_prd);
            check_val("credit_cnt", credit_cnt, prev_iss);
            credit_total += credit_cnt;
            credits      += credit_cnt;
            prev_iss      = int'(mi >= 0) + int'(di >= 0);
            if (mul_issue_valid)
                issue_log.push_back(mul_issue_rob);
            if (div_issue_valid)
                issue_log.push_back(div_issue_rob);
            if (flush) begin
                model.delete();
                credits = DEPTH;    // dispatch restarts its count
            end else begin
                if (mi > di) begin
                    model.delete(mi);
                    if (di >= 0)
                        model.delete(di);
                end else begin
                    if (di >= 0)
                        model.delete(di);
                    if (mi >= 0)
                        model.delete(mi);
                end
                if (enq_valid_0)
                    model.push_back(lane0);
                if (enq_valid_1)
                    model.push_back(lane1);
                credits -= int'(enq_valid_0) + int'(enq_valid_1);
                for (int i = 0; i < model.size(); i++) begin
                    for (int p = 0; p < `MDU_WAKE_PORTS; p++) begin
                        if (wake_valid[p] && wake_preg[p] == model[i].prs1)
                            model[i].prs1_rdy = 1'b1;
                        if (wake_valid[p] && wake_preg[p] == model[i].prs2)
                            model[i].prs2_rdy = 1'b1;
                    end
                end
            end
        end
    end

    task automatic test_reset_idle();
        idle(6);
        check_val("issue count", issue_log.size(), 0);
        check_val("credit total", credit_total, 0);
    endtask

    task automatic test_route();
        int base;
        int start;
        base  = issue_log.size();
        start = credit_total;
        drive(2'b11, mk(OP_MUL, 1, 5, 6, 1, 1), mk(OP_DIV, 2, 7, 8, 1, 1), 2'b00, '0, '0);
        idle(3);
        check_val("issue count", issue_log.size() - base, 2);
        check_val("credits returned", credit_total - start, 2);
    endtask

    task automatic test_wakeup();
        int base;
        base = issue_log.size();
        drive(2'b11, mk(OP_MUL, 3, 10, 11, 0, 0), mk(OP_DIV, 4, 12, 13, 1, 0), 2'b00, '0, '0);
        drive(2'b00, '0, '0, 2'b01, 20, '0);    // tag nobody waits on
        drive(2'b00, '0, '0, 2'b10, '0, 10);
        idle(2);
        check_val("issues before last wake", issue_log.size() - base, 0);
        drive(2'b00, '0, '0, 2'b11, 11, 13);
        idle(2);
        check_val("issues after last wake", issue_log.size() - base, 2);
        // wake lands in the same cycle as the enqueue
        drive(2'b01, mk(OP_MULH, 5, 14, 15, 0, 0), '0, 2'b11, 14, 15);
        idle(2);
        check_val("issues after enqueue wake", issue_log.size() - base, 3);
    endtask

    task automatic test_busy_order();
        int                    base;
        logic [`MDU_ROB_W-1:0] order [6] = '{11, 13, 15, 10, 12, 14};
        base = issue_log.size();
        drive(2'b11, mk(OP_MUL, 10, 1, 2, 1, 1), mk(OP_DIV, 11, 3, 4, 1, 1), 2'b00, '0, '0);
        mul_busy <= 1'b1;
        drive(2'b11, mk(OP_MULH, 12, 5, 6, 1, 1), mk(OP_DIV, 13, 7, 8, 1, 1), 2'b00, '0, '0);
        drive(2'b11, mk(OP_MUL, 14, 9, 1, 1, 1), mk(OP_REM, 15, 2, 3, 1, 1), 2'b00, '0, '0);
        idle(3);
        check_val("issues under mul_busy", issue_log.size() - base, 3);
        idle(1);
        mul_busy <= 1'b0;
        idle(5);
        check_val("issue count", issue_log.size() - base, 6);
        for (int k = 0; k < 6; k++) begin
            check_val($sformatf("issue_log[%0d]", k), issue_log[base+k], order[k]);
        end
        // divide unit stalled while a younger MULH passes
        div_busy <= 1'b1;
        drive(2'b11, mk(OP_REM, 16, 1, 2, 1, 1), mk(OP_MULH, 17, 3, 4, 1, 1), 2'b00, '0, '0);
        idle(3);
        check_val("issues under div_busy", issue_log.size() - base, 7);
        div_busy <= 1'b0;
        idle(2);
        check_val("issue count", issue_log.size() - base, 8);
        check_val("issue_log[6]", issue_log[base+6], 17);
        check_val("issue_log[7]", issue_log[base+7], 16);
    endtask

    task automatic test_credits();
        preg_t    tags [16];
        int       start;
        int       waited;
        mdu_uop_t u0;
        mdu_uop_t u1;
        for (int k = 0; k < 4; k++) begin
            for (int t = 0; t < 4; t++) begin
                tags[4*k+t] = preg_t'(rand_bits(6));
            end
            u0 = mk(mdu_op_e'(rand_bits(2)), 32 + 2*k, tags[4*k], tags[4*k+1], 0, 0);
            u1 = mk(mdu_op_e'(rand_bits(2)), 33 + 2*k, tags[4*k+2], tags[4*k+3], 0, 0);
            drive(2'b11, u0, u1, 2'b00, '0, '0);
        end
        idle(1);
        check_val("credits", credits, 0);
        start = credit_total;
        for (int k = 0; k < 8; k++) begin
            drive(2'b00, '0, '0, 2'b11, tags[2*k], tags[2*k+1]);
        end
        waited = 0;
        while ((credit_total - start < DEPTH) && (waited < 20)) begin
            idle(1);
            waited++;
        end
        check_val("credits returned", credit_total - start, DEPTH);
        idle(2);
        check_val("credits", credits, DEPTH);
    endtask

    task automatic test_flush();
        int base;
        base = issue_log.size();
        drive(2'b11, mk(OP_MUL, 48, 40, 41, 0, 0), mk(OP_DIV, 49, 42, 43, 0, 0), 2'b00, '0, '0);
        drive(2'b11, mk(OP_MULH, 50, 44, 45, 0, 0), mk(OP_REM, 51, 46, 47, 0, 0),
              2'b11, 40, 41);
        drive(2'b00, '0, '0, 2'b00, '0, '0);
        flush <= 1'b1;                          // rob 48 is ready here
        drive(2'b00, '0, '0, 2'b11, 42, 43);
        flush <= 1'b0;
        drive(2'b00, '0, '0, 2'b11, 44, 45);
        drive(2'b00, '0, '0, 2'b11, 46, 47);
        idle(1);
        check_val("issues of flushed entries", issue_log.size() - base, 0);
        check_val("credits", credits, DEPTH);
        drive(2'b11, mk(OP_MULH, 52, 1, 2, 1, 1), mk(OP_REM, 53, 3, 4, 1, 1), 2'b00, '0, '0);
        idle(2);
        check_val("issue count", issue_log.size() - base, 2);
        if (issue_log.size() - base == 2) begin
            check_val("issue_log mul", issue_log[base], 52);
            check_val("issue_log div", issue_log[base+1], 53);
        end
    endtask

    initial begin
        rst          = 1'b1;
        flush        = 1'b0;
        enq_valid_0  = 1'b0;
        enq_valid_1  = 1'b0;
        lane0        = '0;
        lane1        = '0;
        wake_valid   = '0;
        wake_preg    = '0;
        mul_busy     = 1'b0;
        div_busy     = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset_idle();
        test_route();
        test_wakeup();
        test_busy_order();
        test_credits();
        test_flush();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/mdu_issue_chk.sv
`default_nettype none

`include "mdu_iq_settings.svh"

module mdu_issue_chk (
    input wire                          clk,
    input wire                          rst,
    input wire                          flush,
    input wire                          enq_valid_0,
    input wire                          enq_valid_1,
    input wire                          mul_issue_valid,
    input wire mdu_uop_pkg::mdu_op_e    mul_issue_op,
    input wire                          div_issue_valid,
    input wire mdu_uop_pkg::mdu_op_e    div_issue_op,
    input wire [1:0]                    credit_cnt
);
    timeunit 1ns;
    timeprecision 100ps;
    import mdu_uop_pkg::*;

    int         credits;                // dispatch side view of free slots
    logic [1:0] n_iss;

    assign n_iss = {1'b0, mul_issue_valid} + {1'b0, div_issue_valid};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            credits <= `MDU_IQ_DEPTH;
        end else begin
            credits <= credits + int'(credit_cnt) - int'(enq_valid_0) - int'(enq_valid_1);
        end
    end

    a_enq_credit: assert property (@(posedge clk) disable iff (rst || flush)
        int'(enq_valid_0) + int'(enq_valid_1) <= credits)
        else $error("enqueue with no credit left");

    a_credit_ret: assert property (@(posedge clk) disable iff (rst)
        credit_cnt == $past(n_iss))
        else $error("credit_cnt does not match last cycle's issues");

    a_mul_class: assert property (@(posedge clk) disable iff (rst)
        mul_issue_valid |-> mul_issue_op inside {OP_MUL, OP_MULH})
        else $error("divide op on the mul issue port");

    a_div_class: assert property (@(posedge clk) disable iff (rst)
        div_issue_valid |-> div_issue_op inside {OP_DIV, OP_REM})
        else $error("multiply op on the div issue port");

    a_flush_quiet: assert property (@(posedge clk) disable iff (rst)
        flush |=> !mul_issue_valid && !div_issue_valid)
        else $error("issue in the cycle after flush");

endmodule

bind mdu_issue_unit mdu_issue_chk i_chk (
    .clk             (clk),
    .rst             (rst),
    .flush           (flush),
    .enq_valid_0     (enq_valid_0),
    .enq_valid_1     (enq_valid_1),
    .mul_issue_valid (mul_issue_valid),
    .mul_issue_op    (mul_issue_op),
    .div_issue_valid (div_issue_valid),
    .div_issue_op    (div_issue_op),
    .credit_cnt      (credit_cnt)
);

`default_nettype wire

//--- design/mdu_issue_unit.sv
`default_nettype none

`include "mdu_iq_settings.svh"

module mdu_issue_unit (
    input  wire                                             clk,
    input  wire                                             rst,
    input  wire                                             flush,
    input  wire                                             enq_valid_0,
    input  wire mdu_uop_pkg::mdu_op_e                       enq_op_0,
    input  wire [`MDU_ROB_W-1:0]                            enq_rob_0,
    input  wire mdu_uop_pkg::preg_t                         enq_prs1_0,
    input  wire mdu_uop_pkg::preg_t                         enq_prs2_0,
    input  wire mdu_uop_pkg::preg_t                         enq_prd_0,
    input  wire                                             enq_prs1_rdy_0,
    input  wire                                             enq_prs2_rdy_0,
    input  wire                                             enq_valid_1,
    input  wire mdu_uop_pkg::mdu_op_e                       enq_op_1,
    input  wire [`MDU_ROB_W-1:0]                            enq_rob_1,
    input  wire mdu_uop_pkg::preg_t                         enq_prs1_1,
    input  wire mdu_uop_pkg::preg_t                         enq_prs2_1,
    input  wire mdu_uop_pkg::preg_t                         enq_prd_1,
    input  wire                                             enq_prs1_rdy_1,
    input  wire                                             enq_prs2_rdy_1,
    input  wire [`MDU_WAKE_PORTS-1:0]                       wake_valid,
    input  wire mdu_uop_pkg::preg_t [`MDU_WAKE_PORTS-1:0]   wake_preg,
    input  wire                                             mul_busy,
    input  wire                                             div_busy,
    output logic                                            mul_issue_valid,
    output mdu_uop_pkg::mdu_op_e                            mul_issue_op,
    output logic [`MDU_ROB_W-1:0]                           mul_issue_rob,
    output mdu_uop_pkg::preg_t                              mul_issue_prs1,
    output mdu_uop_pkg::preg_t                              mul_issue_prs2,
    output mdu_uop_pkg::preg_t                              mul_issue_prd,
    output logic                                            div_issue_valid,
    output mdu_uop_pkg::mdu_op_e                            div_issue_op,
    output logic [`MDU_ROB_W-1:0]                           div_issue_rob,
    output mdu_uop_pkg::preg_t                              div_issue_prs1,
    output mdu_uop_pkg::preg_t                              div_issue_prs2,
    output mdu_uop_pkg::preg_t                              div_issue_prd,
    output logic [1:0]                                      credit_cnt
);
    import mdu_uop_pkg::*;
    import mdu_iq_pkg::*;

    mdu_uop_t enq_uop_0;
    mdu_uop_t enq_uop_1;
    mdu_uop_t mul_uop;
    mdu_uop_t div_uop;
    iq_vec_t  slot_valid;
    iq_vec_t  slot_ready;
    iq_vec_t  slot_class;
    logic     pick_mul;
    logic     pick_div;
    iq_idx_t  pick_mul_idx;
    iq_idx_t  pick_div_idx;

    assign enq_uop_0 = '{op: enq_op_0, rob_tag: enq_rob_0, prs1: enq_prs1_0,
                         prs2: enq_prs2_0, prd: enq_prd_0,
                         prs1_rdy: enq_prs1_rdy_0, prs2_rdy: enq_prs2_rdy_0};
    assign enq_uop_1 = '{op: enq_op_1, rob_tag: enq_rob_1, prs1: enq_prs1_1,
                         prs2: enq_prs2_1, prd: enq_prd_1,
                         prs1_rdy: enq_prs1_rdy_1, prs2_rdy: enq_prs2_rdy_1};

    mdu_iq_queue i_queue (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .enq_valid_0  (enq_valid_0),
        .enq_uop_0    (enq_uop_0),
        .enq_valid_1  (enq_valid_1),
        .enq_uop_1    (enq_uop_1),
        .wake_valid   (wake_valid),
        .wake_preg    (wake_preg),
        .pick_mul     (pick_mul),
        .pick_div     (pick_div),
        .pick_mul_idx (pick_mul_idx),
        .pick_div_idx (pick_div_idx),
        .slot_valid   (slot_valid),
        .slot_ready   (slot_ready),
        .slot_class   (slot_class),
        .mul_uop      (mul_uop),
        .div_uop      (div_uop)
    );

    mdu_issue_select i_select (
        .slot_valid   (slot_valid),
        .slot_ready   (slot_ready),
        .slot_class   (slot_class),
        .mul_busy     (mul_busy),
        .div_busy     (div_busy),
        .pick_mul     (pick_mul),
        .pick_div     (pick_div),
        .pick_mul_idx (pick_mul_idx),
        .pick_div_idx (pick_div_idx)
    );

    // nothing leaves the queue on a flush cycle
    assign mul_issue_valid = pick_mul && !flush;
    assign mul_issue_op    = mul_uop.op;
    assign mul_issue_rob   = mul_uop.rob_tag;
    assign mul_issue_prs1  = mul_uop.prs1;
    assign mul_issue_prs2  = mul_uop.prs2;
    assign mul_issue_prd   = mul_uop.prd;

    assign div_issue_valid = pick_div && !flush;
    assign div_issue_op    = div_uop.op;
    assign div_issue_rob   = div_uop.rob_tag;
    assign div_issue_prs1  = div_uop.prs1;
    assign div_issue_prs2  = div_uop.prs2;
    assign div_issue_prd   = div_uop.prd;

    // one credit per slot freed last cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            credit_cnt <= 2'd0;
        end else begin
            credit_cnt <= {1'b0, mul_issue_valid} + {1'b0, div_issue_valid};
        end
    end

endmodule

`default_nettype wire

//--- design/mdu_issue_select.sv
`default_nettype none

`include "mdu_iq_settings.svh"

module mdu_issue_select (
    input  wire mdu_iq_pkg::iq_vec_t    slot_valid,
    input  wire mdu_iq_pkg::iq_vec_t    slot_ready,
    input  wire mdu_iq_pkg::iq_vec_t    slot_class,
    input  wire                         mul_busy,
    input  wire                         div_busy,
    output logic                        pick_mul,
    output logic                        pick_div,
    output mdu_iq_pkg::iq_idx_t         pick_mul_idx,
    output mdu_iq_pkg::iq_idx_t         pick_div_idx
);
    import mdu_iq_pkg::*;

    iq_vec_t mul_cand;
    iq_vec_t div_cand;
    logic    mul_any;
    logic    div_any;

    // lowest set bit, i.e. the oldest candidate
    function automatic iq_idx_t first_set(input iq_vec_t v);
        first_set = '0;
        for (int i = `MDU_IQ_DEPTH - 1; i >= 0; i--) begin
            if (v[i]) begin
                first_set = iq_idx_t'(i);
            end
        end
    endfunction

    always_comb begin
        for (int i = 0; i < `MDU_IQ_DEPTH; i++) begin
            mul_cand[i] = slot_valid[i] && slot_ready[i]
                       && (exu_class_e'(slot_class[i]) == CLASS_MUL);
            div_cand[i] = slot_valid[i] && slot_ready[i]
                       && (exu_class_e'(slot_class[i]) == CLASS_DIV);
        end
    end

    assign mul_any = |mul_cand;
    assign div_any = |div_cand;

    assign pick_mul     = mul_any && !mul_busy;   // busy unit holds its class in place
    assign pick_div     = div_any && !div_busy;
    assign pick_mul_idx = first_set(mul_cand);
    assign pick_div_idx = first_set(div_cand);

endmodule

`default_nettype wire

//--- design/mdu_iq_queue.sv
`default_nettype none

`include "mdu_iq_settings.svh"

module mdu_iq_queue (
    input  wire                                             clk,
    input  wire                                             rst,
    input  wire                                             flush,
    input  wire                                             enq_valid_0,
    input  wire mdu_uop_pkg::mdu_uop_t                      enq_uop_0,
    input  wire                                             enq_valid_1,
    input  wire mdu_uop_pkg::mdu_uop_t                      enq_uop_1,
    input  wire [`MDU_WAKE_PORTS-1:0]                       wake_valid,
    input  wire mdu_uop_pkg::preg_t [`MDU_WAKE_PORTS-1:0]   wake_preg,
    input  wire                                             pick_mul,
    input  wire                                             pick_div,
    input  wire mdu_iq_pkg::iq_idx_t                        pick_mul_idx,
    input  wire mdu_iq_pkg::iq_idx_t                        pick_div_idx,
    output mdu_iq_pkg::iq_vec_t                             slot_valid,
    output mdu_iq_pkg::iq_vec_t                             slot_ready,
    output mdu_iq_pkg::iq_vec_t                             slot_class,
    output mdu_uop_pkg::mdu_uop_t                           mul_uop,
    output mdu_uop_pkg::mdu_uop_t                           div_uop
);
    import mdu_uop_pkg::*;
    import mdu_iq_pkg::*;

    localparam int DEPTH = `MDU_IQ_DEPTH;

    iq_cnt_t  tail;
    iq_cnt_t  n_pick;
    iq_cnt_t  n_enq;
    iq_cnt_t  keep;                     // survivors after this cycle's picks
    mdu_uop_t slot_uop [DEPTH+2];       // two empty slots above the top

    assign n_pick = iq_cnt_t'(pick_mul) + iq_cnt_t'(pick_div);
    assign n_enq  = iq_cnt_t'(enq_valid_0) + iq_cnt_t'(enq_valid_1);
    assign keep   = tail - n_pick;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else begin
            tail <= keep + n_enq;
        end
    end

    assign slot_uop[DEPTH]   = '0;
    assign slot_uop[DEPTH+1] = '0;

    for (genvar j = 0; j < DEPTH; j++) begin : g_slot
        logic [1:0] le0;                // picks at or below this slot
        logic [1:0] le1;                // picks at or below the slot above
        logic [1:0] sel;
        logic       ld;
        mdu_uop_t   ld_uop;

        assign le0 = {1'b0, pick_mul && (pick_mul_idx <= j)}
                   + {1'b0, pick_div && (pick_div_idx <= j)};
        assign le1 = {1'b0, pick_mul && (pick_mul_idx <= j + 1)}
                   + {1'b0, pick_div && (pick_div_idx <= j + 1)};

        always_comb begin
            sel    = 2'd3;
            ld     = 1'b0;
            ld_uop = enq_uop_0;
            if (j < keep) begin
                sel = (le0 == 2'd0) ? 2'd0 : le1;
            end else if (enq_valid_0 && (j == keep)) begin
                ld = 1'b1;
            end else if (enq_valid_1 && (j == keep + 1)) begin
                ld     = 1'b1;
                ld_uop = enq_uop_1;
            end
        end

        mdu_iq_entry i_entry (
            .clk        (clk),
            .rst        (rst),
            .flush      (flush),
            .load       (ld),
            .load_uop   (ld_uop),
            .shift_sel  (sel),
            .up1_uop    (slot_uop[j+1]),
            .up2_uop    (slot_uop[j+2]),
            .wake_valid (wake_valid),
            .wake_preg  (wake_preg),
            .uop        (slot_uop[j]),
            .valid      (slot_valid[j]),
            .ready      (slot_ready[j])
        );

        assign slot_class[j] = (slot_uop[j].op == OP_DIV) || (slot_uop[j].op == OP_REM);
    end

    assign mul_uop = slot_uop[pick_mul_idx];
    assign div_uop = slot_uop[pick_div_idx];

endmodule

`default_nettype wire

//--- design/mdu_iq_entry.sv
`default_nettype none

`include "mdu_iq_settings.svh"

module mdu_iq_entry (
    input  wire                                             clk,
    input  wire                                             rst,
    input  wire                                             flush,
    input  wire                                             load,
    input  wire mdu_uop_pkg::mdu_uop_t                      load_uop,
    input  wire [1:0]                                       shift_sel,
    input  wire mdu_uop_pkg::mdu_uop_t                      up1_uop,
    input  wire mdu_uop_pkg::mdu_uop_t                      up2_uop,
    input  wire [`MDU_WAKE_PORTS-1:0]                       wake_valid,
    input  wire mdu_uop_pkg::preg_t [`MDU_WAKE_PORTS-1:0]   wake_preg,
    output mdu_uop_pkg::mdu_uop_t                           uop,
    output logic                                            valid,
    output logic                                            ready
);
    import mdu_uop_pkg::*;

    mdu_uop_t nxt_uop;
    mdu_uop_t wake_uop;
    logic     nxt_valid;
    logic     rs1_hit;
    logic     rs2_hit;

    // shift_sel: 0 hold, 1 next slot up, 2 two slots up, 3 slot drains
    always_comb begin
        nxt_uop   = uop;
        nxt_valid = valid;
        if (load) begin
            nxt_uop   = load_uop;
            nxt_valid = 1'b1;
        end else begin
            case (shift_sel)
                2'd1: begin
                    nxt_uop   = up1_uop;
                    nxt_valid = 1'b1;
                end
                2'd2: begin
                    nxt_uop   = up2_uop;
                    nxt_valid = 1'b1;
                end
                2'd3: begin
                    nxt_valid = 1'b0;
                end
                default: begin
                    nxt_valid = valid;
                end
            endcase
        end
    end

    // wake applies to whatever lands here, including a fresh enqueue
    always_comb begin
        rs1_hit = 1'b0;
        rs2_hit = 1'b0;
        for (int p = 0; p < `MDU_WAKE_PORTS; p++) begin
            rs1_hit = rs1_hit | (wake_valid[p] && (wake_preg[p] == nxt_uop.prs1));
            rs2_hit = rs2_hit | (wake_valid[p] && (wake_preg[p] == nxt_uop.prs2));
        end
        wake_uop          = nxt_uop;
        wake_uop.prs1_rdy = nxt_uop.prs1_rdy | rs1_hit;
        wake_uop.prs2_rdy = nxt_uop.prs2_rdy | rs2_hit;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= 1'b0;
        end else begin
            valid <= nxt_valid;
        end
    end

    always_ff @(posedge clk) begin
        uop <= wake_uop;
    end

    assign ready = valid && uop.prs1_rdy && uop.prs2_rdy;

endmodule

`default_nettype wire

//--- design/mdu_iq_pkg.sv
`default_nettype none

`include "mdu_iq_settings.svh"

package mdu_iq_pkg;

    // slot number
    typedef logic [$clog2(`MDU_IQ_DEPTH)-1:0] iq_idx_t;

    // occupancy, 0 up to full
    typedef logic [$clog2(`MDU_IQ_DEPTH + 1)-1:0] iq_cnt_t;

    // one bit per slot
    typedef logic [`MDU_IQ_DEPTH-1:0] iq_vec_t;

    typedef enum logic {
        CLASS_MUL = 1'b0,
        CLASS_DIV = 1'b1
    } exu_class_e;

endpackage

`default_nettype wire

//--- design/mdu_uop_pkg.sv
`default_nettype none

`include "mdu_iq_settings.svh"

package mdu_uop_pkg;

    // bit 1 set means divide unit
    typedef enum logic [1:0] {
        OP_MUL  = 2'b00,    // low half of product
        OP_MULH = 2'b01,    // high half of product
        OP_DIV  = 2'b10,
        OP_REM  = 2'b11
    } mdu_op_e;

    typedef logic [`MDU_PREG_W-1:0] preg_t;

    // renamed micro-op, tags only
    typedef struct packed {
        mdu_op_e                op;
        logic [`MDU_ROB_W-1:0]  rob_tag;
        preg_t                  prs1;
        preg_t                  prs2;
        preg_t                  prd;
        logic                   prs1_rdy;
        logic                   prs2_rdy;
    } mdu_uop_t;

endpackage

`default_nettype wire

//--- include/mdu_iq_settings.svh
`ifndef MDU_IQ_SETTINGS_SVH
`define MDU_IQ_SETTINGS_SVH

// queue slots, slot 0 holds the oldest micro-op
`define MDU_IQ_DEPTH    8

// writeback wake ports
`define MDU_WAKE_PORTS  2

// physical register tag width
`define MDU_PREG_W      6

// reorder buffer tag width
`define MDU_ROB_W       6

`endif
